// ==== hdl/dmc_clk_pkg.sv ====
package dmc_clk_pkg;

  // field widths of one tag packet
  localparam int node_id_width = 3;
  localparam int payload_width = 8;

  // node map of the tag clients
  localparam int node_reset_id = 0;
  localparam int node_ds_id = 1;
  // delay line i listens on node_dly_base_id + i
  localparam int node_dly_base_id = 2;

  typedef logic [node_id_width-1:0] node_id_t;

  // half period of the 1x clock is ratio + 1 cycles of clk_i
  typedef logic [3:0] ratio_t;

  // delay line lag is tap + 1 cycles of clk_i
  typedef logic [2:0] tap_t;

  // node 0, controller reset level
  typedef struct packed {
    logic       reset_level;
    logic [6:0] spare;
  } reset_payload_s;

  // node 1, downsampler control
  typedef struct packed {
    logic       ds_reset;
    ratio_t     ratio;
    logic [2:0] spare;
  } ds_payload_s;

  // delay nodes, one per line
  typedef struct packed {
    tap_t       tap;
    logic [4:0] spare;
  } dly_payload_s;

  // one payload word, read through the view that the node id selects
  typedef union packed {
    logic [payload_width-1:0] raw;
    reset_payload_s           rst;
    ds_payload_s              ds;
    dly_payload_s             dly;
  } tag_payload_u;

  // node id goes out first on the serial line, so it sits in the upper bits
  typedef struct packed {
    node_id_t     node;
    tag_payload_u payload;
  } tag_packet_s;

endpackage

// ==== hdl/tag_serial_rx.sv ====
`timescale 1ns/1ps

module tag_serial_rx (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     tag_bit_i,
  output dmc_clk_pkg::tag_packet_s pkt_o,
  output logic                     pkt_v_o
);

  // bits after the start bit
  localparam int pkt_bits_lp = $bits(dmc_clk_pkg::tag_packet_s);
  localparam int cnt_width_lp = $clog2(pkt_bits_lp);

  typedef enum logic {
    idle_s,
    shift_s
  } state_e;

  state_e                  state_r;
  logic [cnt_width_lp-1:0] bit_cnt_r;
  logic [pkt_bits_lp-1:0]  shift_r;
  logic                    pkt_v_r;
  logic                    last_bit;

  // the edge that samples the final payload bit
  assign last_bit = (state_r == shift_s) &&
                    (bit_cnt_r == cnt_width_lp'(pkt_bits_lp - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r   <= idle_s;
      bit_cnt_r <= '0;
      pkt_v_r   <= 1'b0;
    end else begin
      pkt_v_r <= last_bit;
      case (state_r)
        idle_s: begin
          // a high bit on an idle line opens a packet
          if (tag_bit_i) begin
            state_r   <= shift_s;
            bit_cnt_r <= '0;
          end
        end
        shift_s: begin
          if (last_bit) begin
            // back to idle at once, a start bit may follow directly
            state_r <= idle_s;
          end else begin
            bit_cnt_r <= bit_cnt_r + 1'b1;
          end
        end
        default: begin
          state_r <= idle_s;
        end
      endcase
    end
  end

  // msb first, node id then payload
  // the start bit is not shifted in, so the word holds still while pkt_v_o is high
  always_ff @(posedge clk_i) begin
    if (state_r == shift_s) begin
      shift_r <= {shift_r[pkt_bits_lp-2:0], tag_bit_i};
    end
  end

  assign pkt_o   = shift_r;
  assign pkt_v_o = pkt_v_r;

  // a packet needs a start bit plus eleven data bits, so valid can never repeat
  a_pkt_v_single : assert property (
    @(posedge clk_i) disable iff (rst_i)
    pkt_v_o |=> !pkt_v_o
  ) else $error("pkt_v_o high on two consecutive cycles");

endmodule

// ==== hdl/tag_client.sv ====
`timescale 1ns/1ps

module tag_client #(
  parameter dmc_clk_pkg::node_id_t                  node_p      = '0,
  parameter logic [dmc_clk_pkg::payload_width-1:0] reset_val_p = '0
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  dmc_clk_pkg::tag_packet_s  pkt_i,
  input  logic                      pkt_v_i,
  output dmc_clk_pkg::tag_payload_u data_o,
  output logic                      new_o
);

  dmc_clk_pkg::tag_payload_u data_r;
  logic                      new_r;
  logic                      hit;

  // packets for other nodes pass by untouched
  assign hit = pkt_v_i && (pkt_i.node == node_p);

  // payload register, taken from a packet addressed to this node
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_r <= reset_val_p;
    end else if (hit) begin
      data_r <= pkt_i.payload;
    end
  end

  // one cycle pulse alongside each new word
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      new_r <= 1'b0;
    end else begin
      new_r <= hit;
    end
  end

  assign data_o = data_r;
  assign new_o  = new_r;

endmodule

// ==== hdl/clk_downsample.sv ====
`timescale 1ns/1ps

module clk_downsample (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  dmc_clk_pkg::ds_payload_s cfg_i,
  output logic                     clk_1x_o
);

  dmc_clk_pkg::ratio_t count_r;
  dmc_clk_pkg::ratio_t ratio_r;
  dmc_clk_pkg::ratio_t limit;
  logic                clk_1x_r;

  // the ratio is picked up on the first cycle of each half period,
  // so a new value only shows after the next toggle
  assign limit = (count_r == '0) ? cfg_i.ratio : ratio_r;

  always_ff @(posedge clk_i) begin
    if (count_r == '0) begin
      ratio_r <= cfg_i.ratio;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || cfg_i.ds_reset) begin
      // parked, the divider holds still to save power
      count_r  <= '0;
      clk_1x_r <= 1'b0;
    end else if (count_r == limit) begin
      count_r  <= '0;
      clk_1x_r <= ~clk_1x_r;
    end else begin
      count_r <= count_r + 1'b1;
    end
  end

  assign clk_1x_o = clk_1x_r;

  // parking must reach the output within one edge
  a_park_low : assert property (
    @(posedge clk_i) disable iff (rst_i)
    cfg_i.ds_reset |=> !clk_1x_o
  ) else $error("clk_1x_o not low after ds_reset");

endmodule

// ==== hdl/dly_line.sv ====
`timescale 1ns/1ps

module dly_line #(
  parameter int max_taps_p = 8
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  dmc_clk_pkg::tap_t   tap_i,
  input  logic                clk_i_line_i,
  output logic                clk_o
);

  // every legal tap value has to select a real stage
  if (max_taps_p < 2 || max_taps_p > 2**$bits(dmc_clk_pkg::tap_t)) begin : g_bad_depth
    $error("max_taps_p out of range for tap_t");
  end

  // stage 0 is one cycle behind the 1x waveform
  logic [max_taps_p-1:0] stage_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stage_r <= '0;
    end else begin
      stage_r <= {stage_r[max_taps_p-2:0], clk_i_line_i};
    end
  end

  // tap t reads stage t, which lags by t + 1 cycles
  assign clk_o = stage_r[tap_i];

  a_tap_range : assert property (
    @(posedge clk_i) disable iff (rst_i)
    tap_i < max_taps_p
  ) else $error("tap_i %0d beyond line depth %0d", tap_i, max_taps_p);

endmodule

// ==== hdl/dmc_clk_rst_gen.sv ====
`timescale 1ns/1ps

module dmc_clk_rst_gen #(
  parameter int num_lines_p = 2,
  parameter int max_taps_p  = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   tag_bit_i,
  // controller reset level, held high out of reset
  output logic                   async_reset_o,
  // 1x clock waveform from the divider
  output logic                   dfi_clk_1x_o,
  // delayed copies of the 1x waveform for the strobes
  output logic [num_lines_p-1:0] clk_o
);

  // controller held in reset until software lets it go
  localparam dmc_clk_pkg::reset_payload_s rst_default_lp = '{
    reset_level: 1'b1,
    spare:       '0
  };

  // divider parked until software starts it
  localparam dmc_clk_pkg::ds_payload_s ds_default_lp = '{
    ds_reset: 1'b1,
    ratio:    '0,
    spare:    '0
  };

  dmc_clk_pkg::tag_packet_s  pkt;
  logic                      pkt_v;
  dmc_clk_pkg::tag_payload_u rst_data;
  dmc_clk_pkg::tag_payload_u ds_data;

  tag_serial_rx i_tag_serial_rx (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .tag_bit_i (tag_bit_i),
    .pkt_o     (pkt),
    .pkt_v_o   (pkt_v)
  );

  // the new pulses are left open, every consumer follows the level

  tag_client #(
    .node_p      (dmc_clk_pkg::node_id_t'(dmc_clk_pkg::node_reset_id)),
    .reset_val_p (rst_default_lp)
  ) i_tag_client_rst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .pkt_i   (pkt),
    .pkt_v_i (pkt_v),
    .data_o  (rst_data),
    .new_o   ()
  );

  assign async_reset_o = rst_data.rst.reset_level;

  tag_client #(
    .node_p      (dmc_clk_pkg::node_id_t'(dmc_clk_pkg::node_ds_id)),
    .reset_val_p (ds_default_lp)
  ) i_tag_client_ds (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .pkt_i   (pkt),
    .pkt_v_i (pkt_v),
    .data_o  (ds_data),
    .new_o   ()
  );

  clk_downsample i_clk_downsample (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .cfg_i    (ds_data.ds),
    .clk_1x_o (dfi_clk_1x_o)
  );

  // one tag client and one delay line per strobe clock
  for (genvar i = 0; i < num_lines_p; i++) begin : g_dly
    dmc_clk_pkg::tag_payload_u dly_data;

    tag_client #(
      .node_p      (dmc_clk_pkg::node_id_t'(dmc_clk_pkg::node_dly_base_id + i)),
      .reset_val_p ('0)
    ) i_tag_client_dly (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .pkt_i   (pkt),
      .pkt_v_i (pkt_v),
      .data_o  (dly_data),
      .new_o   ()
    );

    dly_line #(
      .max_taps_p (max_taps_p)
    ) i_dly_line (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .tap_i        (dly_data.dly.tap),
      .clk_i_line_i (dfi_clk_1x_o),
      .clk_o        (clk_o[i])
    );
  end

endmodule

// ==== test/tb_dmc_clk_rst_gen.sv ====
`timescale 1ns/1ps

module tb_dmc_clk_rst_gen;

  localparam int num_lines_lp = 2;
  localparam int line_bits_lp = (num_lines_lp > 1) ? $clog2(num_lines_lp) : 1;
  localparam int timeout_lp = 200;
  localparam logic [31:0] seed_lp = 32'd75;
  localparam int pkt_bits_lp = $bits(dmc_clk_pkg::tag_packet_s);

  typedef logic [line_bits_lp-1:0] line_t;

  // one row of the stimulus table, its name sits in name_q at the same index
  typedef struct packed {
    logic                                  send;
    dmc_clk_pkg::tag_packet_s              pkt;
    logic                                  exp_async;
    logic                                  exp_parked;
    dmc_clk_pkg::ratio_t                   exp_ratio;
    dmc_clk_pkg::tap_t [num_lines_lp-1:0]  exp_tap;
  } entry_s;

  logic                    clk_i = 1'b0;
  logic                    rst_i;
  logic                    tag_bit_i;
  logic                    async_reset_o;
  logic                    dfi_clk_1x_o;
  logic [num_lines_lp-1:0] clk_o;

  entry_s      table_q[$];
  string       name_q[$];
  logic [31:0] rng;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          test_cnt = 0;

  // expected state, tracked while the table is built
  logic                                 cur_async;
  logic                                 cur_parked;
  dmc_clk_pkg::ratio_t                  cur_ratio;
  dmc_clk_pkg::tap_t [num_lines_lp-1:0] cur_tap;

  always #20 clk_i = ~clk_i;

  dmc_clk_rst_gen i_dmc_clk_rst_gen (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .tag_bit_i     (tag_bit_i),
    .async_reset_o (async_reset_o),
    .dfi_clk_1x_o  (dfi_clk_1x_o),
    .clk_o         (clk_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ratios below 4 would let the longest lag wrap past a full 1x period
  function automatic dmc_clk_pkg::ratio_t next_ratio();
    rng = xorshift32(rng);
    return dmc_clk_pkg::ratio_t'(4 + (rng % 12));
  endfunction

  function automatic dmc_clk_pkg::tap_t next_tap();
    rng = xorshift32(rng);
    return dmc_clk_pkg::tap_t'(rng & 32'h7);
  endfunction

  function automatic logic [7:0] next_byte();
    rng = xorshift32(rng);
    return rng[15:8];
  endfunction

  task automatic push_entry(input string name, input logic send,
                            input dmc_clk_pkg::tag_packet_s pkt);
    entry_s e;
    e.send       = send;
    e.pkt        = pkt;
    e.exp_async  = cur_async;
    e.exp_parked = cur_parked;
    e.exp_ratio  = cur_ratio;
    e.exp_tap    = cur_tap;
    table_q.push_back(e);
    name_q.push_back(name);
  endtask

  task automatic add_rst(input string name, input logic level);
    dmc_clk_pkg::tag_packet_s p;
    p.node = dmc_clk_pkg::node_id_t'(dmc_clk_pkg::node_reset_id);
    p.payload.raw = '0;
    p.payload.rst.reset_level = level;
    cur_async = level;
    push_entry(name, 1'b1, p);
  endtask

  task automatic add_ds(input string name, input logic ds_reset,
                        input dmc_clk_pkg::ratio_t ratio);
    dmc_clk_pkg::tag_packet_s p;
    p.node = dmc_clk_pkg::node_id_t'(dmc_clk_pkg::node_ds_id);
    p.payload.raw = '0;
    p.payload.ds.ds_reset = ds_reset;
    p.payload.ds.ratio = ratio;
    cur_parked = ds_reset;
    cur_ratio = ratio;
    push_entry(name, 1'b1, p);
  endtask

  task automatic add_dly(input string name, input line_t line, input dmc_clk_pkg::tap_t tap);
    dmc_clk_pkg::tag_packet_s p;
    p.node = dmc_clk_pkg::node_id_t'(dmc_clk_pkg::node_dly_base_id + int'(line));
    p.payload.raw = '0;
    p.payload.dly.tap = tap;
    cur_tap[line] = tap;
    push_entry(name, 1'b1, p);
  endtask

  // nodes without a client, nothing may change
  task automatic add_raw(input string name, input dmc_clk_pkg::node_id_t node,
                         input logic [7:0] raw);
    dmc_clk_pkg::tag_packet_s p;
    p.node = node;
    p.payload.raw = raw;
    push_entry(name, 1'b1, p);
  endtask

  task automatic build_table();
    cur_async = 1'b1;
    cur_parked = 1'b1;
    cur_ratio = '0;
    cur_tap = '0;
    push_entry("reset_defaults", 1'b0, '0);
    add_rst("rst_release", 1'b0);
    add_rst("rst_assert", 1'b1);
    add_rst("rst_release_again", 1'b0);
    add_ds("ds_ratio_fixed", 1'b0, 4'd5);
    add_ds("ds_ratio_rand_a", 1'b0, next_ratio());
    add_ds("ds_ratio_rand_b", 1'b0, next_ratio());
    add_dly("dly0_rand", line_t'(0), next_tap());
    add_dly("dly1_rand", line_t'(1), next_tap());
    add_dly("dly0_rand_b", line_t'(0), next_tap());
    add_dly("dly1_rand_b", line_t'(1), next_tap());
    add_raw("unused_node7", 3'd7, next_byte());
    add_raw("unused_node5", 3'd5, next_byte());
    add_ds("ds_ratio_rand_c", 1'b0, next_ratio());
    add_rst("rst_assert_final", 1'b1);
    add_ds("ds_park", 1'b1, '0);
  endtask

  task automatic check_level(input string name, input string what,
                             input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL %s: %s expected %0b, actual %0b", name, what, exp, act);
    end
  endtask

  task automatic check_ratio(input string name, input dmc_clk_pkg::ratio_t exp,
                             input dmc_clk_pkg::ratio_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL %s: ratio expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_tap(input string name, input dmc_clk_pkg::tap_t exp,
                           input dmc_clk_pkg::tap_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL %s: tap expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // start bit, then node id and payload msb first, line low afterwards
  task automatic send_packet(input dmc_clk_pkg::tag_packet_s pkt);
    logic [pkt_bits_lp-1:0] bits;
    bits = pkt;
    @(negedge clk_i);
    tag_bit_i = 1'b1;
    repeat (pkt_bits_lp) begin
      @(negedge clk_i);
      tag_bit_i = bits[pkt_bits_lp-1];
      bits = {bits[pkt_bits_lp-2:0], 1'b0};
    end
    @(negedge clk_i);
    tag_bit_i = 1'b0;
  endtask

  task automatic wait_rise_1x(output logic ok);
    logic prev;
    int   n;
    ok = 1'b0;
    n = 0;
    prev = dfi_clk_1x_o;
    while (!ok && n < timeout_lp) begin
      @(negedge clk_i);
      n++;
      if (!prev && dfi_clk_1x_o) ok = 1'b1;
      prev = dfi_clk_1x_o;
    end
    if (!ok) begin
      err_cnt++;
      $display("no rising edge on dfi_clk_1x_o within timeout");
    end
  endtask

  // count clk_i cycles in one high and one low phase
  task automatic measure_half_periods(input string name, input dmc_clk_pkg::ratio_t exp);
    logic ok;
    int   high_n;
    int   low_n;
    wait_rise_1x(ok);
    if (ok) begin
      high_n = 1;
      @(negedge clk_i);
      while (dfi_clk_1x_o && high_n < timeout_lp) begin
        high_n++;
        @(negedge clk_i);
      end
      low_n = 1;
      @(negedge clk_i);
      while (!dfi_clk_1x_o && low_n < timeout_lp) begin
        low_n++;
        @(negedge clk_i);
      end
      if (high_n >= timeout_lp || low_n >= timeout_lp) begin
        err_cnt++;
        $display("dfi_clk_1x_o stopped toggling within timeout in %s", name);
      end else begin
        check_ratio(name, exp, dmc_clk_pkg::ratio_t'(high_n - 1));
        check_ratio(name, exp, dmc_clk_pkg::ratio_t'(low_n - 1));
      end
    end
  endtask

  // cycles from a 1x rising edge to the next rising edge of one line
  task automatic measure_lag(input string name, input line_t line,
                             input dmc_clk_pkg::tap_t exp);
    logic ok;
    logic found;
    logic prev;
    int   n;
    wait_rise_1x(ok);
    if (ok) begin
      found = 1'b0;
      n = 0;
      prev = clk_o[line];
      while (!found && n < timeout_lp) begin
        @(negedge clk_i);
        n++;
        if (!prev && clk_o[line]) found = 1'b1;
        prev = clk_o[line];
      end
      if (found) begin
        check_tap(name, exp, dmc_clk_pkg::tap_t'(n - 1));
      end else begin
        err_cnt++;
        $display("no rising edge on clk_o[%0d] within timeout", line);
      end
    end
  endtask

  // a parked divider shows no high level over the whole window
  task automatic expect_parked(input string name);
    logic seen_high;
    seen_high = 1'b0;
    repeat (timeout_lp) begin
      @(negedge clk_i);
      seen_high = seen_high | dfi_clk_1x_o;
    end
    check_level(name, "dfi_clk_1x_o", 1'b0, seen_high);
  endtask

  task automatic run_entry(input int idx);
    entry_s e;
    string  name;
    int     errs_before;
    line_t  lidx;
    e = table_q[idx];
    name = name_q[idx];
    errs_before = err_cnt;
    if (e.send) begin
      send_packet(e.pkt);
      // client registers settle two cycles after the last bit
      @(negedge clk_i);
      @(negedge clk_i);
    end
    check_level(name, "async_reset_o", e.exp_async, async_reset_o);
    if (e.exp_parked) begin
      expect_parked(name);
    end else begin
      measure_half_periods(name, e.exp_ratio);
      for (int l = 0; l < num_lines_lp; l++) begin
        lidx = line_t'(l);
        measure_lag(name, lidx, e.exp_tap[lidx]);
      end
    end
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  initial begin
    rst_i = 1'b1;
    tag_bit_i = 1'b0;
    rng = seed_lp;
    build_table();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int i = 0; i < table_q.size(); i++) begin
      run_entry(i);
    end
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/dmc_clk_pkg.sv
hdl/tag_serial_rx.sv
hdl/tag_client.sv
hdl/clk_downsample.sv
hdl/dly_line.sv
hdl/dmc_clk_rst_gen.sv
test/tb_dmc_clk_rst_gen.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it into sim.log, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dmc_clk_rst_gen \
  -f filelist.f -o sim_tb > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log && exit 0 || exit 1
